// File: common/ex_pkg.sv
package ex_pkg;

    // --------------------------------------------------
    // widths and fixed addresses
    // --------------------------------------------------
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int SHAMT_W    = $clog2(XLEN);

    // exceptions all land here, no cause register behind it
    localparam logic [XLEN-1:0] TRAP_VECTOR = 32'h0000_0100;

    // --------------------------------------------------
    // encodings
    // --------------------------------------------------
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_e;

    // branch compare, same values as the branch funct3
    typedef enum logic [2:0] {
        CMP_EQ  = 3'b000,
        CMP_NE  = 3'b001,
        CMP_LT  = 3'b100,
        CMP_GE  = 3'b101,
        CMP_LTU = 3'b110,
        CMP_GEU = 3'b111
    } cmp_op_e;

    // load/store funct3
    typedef enum logic [2:0] {
        MEM_BYTE   = 3'b000,
        MEM_HALF   = 3'b001,
        MEM_WORD   = 3'b010,
        MEM_BYTE_U = 3'b100,
        MEM_HALF_U = 3'b101
    } mem_size_e;

    typedef enum logic [1:0] {
        ZONE_NONE,
        ZONE_REGFILE,
        ZONE_LOADQ,
        ZONE_STOREQ
    } zone_e;

    typedef enum logic {
        SOFID_RUN,
        SOFID_JUMP
    } sofid_e;

    typedef enum logic [2:0] {
        EXCP_NONE,
        EXCP_FETCH_ERR,
        EXCP_MISALIGNED_FETCH,
        EXCP_MISALIGNED_LOAD,
        EXCP_MISALIGNED_STORE
    } excp_cause_e;

    // --------------------------------------------------
    // bundles between decoder, stage and consumers
    // --------------------------------------------------
    typedef struct packed {
        sofid_e                sofid;
        logic [1:0]            ins_size;
        logic                  ferr;
        logic                  jump;
        logic                  cond;
        logic                  link;
        zone_e                 zone;
        logic [XLEN-1:0]       pc;
        alu_op_e               alu_op;
        logic [XLEN-1:0]       operand_left;
        logic [XLEN-1:0]       operand_right;
        cmp_op_e               cmp_op;
        logic [XLEN-1:0]       cmp_right;
        logic [XLEN-1:0]       regs1_data;
        logic [XLEN-1:0]       regs2_data;
        logic [REG_ADDR_W-1:0] regd_addr;
        logic [2:0]            funct3;
    } ex_issue_t;

    typedef struct packed {
        logic                  valid;
        logic                  ferr;
        logic                  jump;
        logic                  cond;
        logic                  link;
        logic                  lq_wr;
        logic                  sq_wr;
        logic                  regd_wr;
        logic [XLEN-1:0]       pc;
        logic [XLEN-1:0]       pc_inc;
        logic [XLEN-1:0]       regs2_data;
        logic [REG_ADDR_W-1:0] regd_addr;
        logic [2:0]            funct3;
    } ex_ctrl_t;

    typedef struct packed {
        logic                  wr;
        logic [REG_ADDR_W-1:0] addr;
        logic [XLEN-1:0]       data;
    } ex_wb_t;

    typedef struct packed {
        logic                  lq_wr;
        logic                  sq_wr;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] regd_addr;
        logic [XLEN-1:0]       data;
        logic [XLEN-1:0]       addr;
    } ex_lsq_req_t;

    typedef struct packed {
        logic            valid;
        excp_cause_e     cause;
        logic [XLEN-1:0] pc;
    } ex_excp_t;

endpackage

// File: ex_stage/ex_alu.sv
`timescale 1ns/100ps

module ex_alu (
    input  logic                    clk_i,
    input  logic                    resetb_i,
    input  logic                    stage_en_i,
    input  ex_pkg::ex_issue_t       issue_i,
    output logic [ex_pkg::XLEN-1:0] alu_result_o,
    output logic                    cmp_true_o
);

    logic [ex_pkg::SHAMT_W-1:0] shamt;
    logic [ex_pkg::XLEN-1:0]    alu_d;
    logic                       cmp_d;

    assign shamt = issue_i.operand_right[ex_pkg::SHAMT_W-1:0];

    // --------------------------------------------------
    // arithmetic
    // --------------------------------------------------
    always_comb begin
        case (issue_i.alu_op)
            ex_pkg::ALU_ADD:  alu_d = issue_i.operand_left + issue_i.operand_right;
            ex_pkg::ALU_SUB:  alu_d = issue_i.operand_left - issue_i.operand_right;
            ex_pkg::ALU_SLL:  alu_d = issue_i.operand_left << shamt;
            ex_pkg::ALU_SLT:  alu_d = ex_pkg::XLEN'($signed(issue_i.operand_left) <
                                                   $signed(issue_i.operand_right));
            ex_pkg::ALU_SLTU: alu_d = ex_pkg::XLEN'(issue_i.operand_left <
                                                   issue_i.operand_right);
            ex_pkg::ALU_XOR:  alu_d = issue_i.operand_left ^ issue_i.operand_right;
            ex_pkg::ALU_SRL:  alu_d = issue_i.operand_left >> shamt;
            ex_pkg::ALU_SRA:  alu_d = $unsigned($signed(issue_i.operand_left) >>> shamt);
            ex_pkg::ALU_OR:   alu_d = issue_i.operand_left | issue_i.operand_right;
            ex_pkg::ALU_AND:  alu_d = issue_i.operand_left & issue_i.operand_right;
            default:          alu_d = '0;
        endcase
    end

    // branch compare, rs1 against cmp_right
    always_comb begin
        case (issue_i.cmp_op)
            ex_pkg::CMP_EQ:  cmp_d = issue_i.regs1_data == issue_i.cmp_right;
            ex_pkg::CMP_NE:  cmp_d = issue_i.regs1_data != issue_i.cmp_right;
            ex_pkg::CMP_LT:  cmp_d = $signed(issue_i.regs1_data) < $signed(issue_i.cmp_right);
            ex_pkg::CMP_GE:  cmp_d = $signed(issue_i.regs1_data) >= $signed(issue_i.cmp_right);
            ex_pkg::CMP_LTU: cmp_d = issue_i.regs1_data < issue_i.cmp_right;
            ex_pkg::CMP_GEU: cmp_d = issue_i.regs1_data >= issue_i.cmp_right;
            default:         cmp_d = 1'b0;
        endcase
    end

    // --------------------------------------------------
    // result registers
    // --------------------------------------------------
    always_ff @(posedge clk_i or negedge resetb_i) begin
        if (!resetb_i) begin
            cmp_true_o <= 1'b0;
        end else if (stage_en_i) begin
            cmp_true_o <= cmp_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (stage_en_i) begin
            alu_result_o <= alu_d;
        end
    end

endmodule

// File: ex_stage/ex_commit_ctrl.sv
`timescale 1ns/100ps

module ex_commit_ctrl (
    input  logic                    clk_i,
    input  logic                    resetb_i,
    input  ex_pkg::ex_ctrl_t        ctrl_i,
    input  logic [ex_pkg::XLEN-1:0] alu_result_i,
    input  logic                    cmp_true_i,
    input  ex_pkg::sofid_e          issue_sofid_i,
    input  logic                    issue_valid_i,
    input  logic                    lsq_full_i,
    output logic                    stage_en_o,
    output logic                    commit_o,
    output logic                    jump_req_o,
    output logic                    trap_o,
    output logic                    cancel_load_o,
    output ex_pkg::ex_excp_t        excp_o,
    output logic                    stall_o
);

    ex_pkg::sofid_e      flow_q;
    ex_pkg::excp_cause_e cause;

    logic live;
    logic cond_ok;
    logic commit_raw;
    logic mem_access;
    logic misaligned_acc;
    logic excp_maif;
    logic excp_mala;
    logic excp_masa;

    // --------------------------------------------------
    // qualification
    // --------------------------------------------------
    assign live       = ctrl_i.valid && (flow_q == ex_pkg::SOFID_RUN);
    assign cond_ok    = cmp_true_i || !ctrl_i.cond;
    assign mem_access = ctrl_i.lq_wr || ctrl_i.sq_wr;

    // --------------------------------------------------
    // exception detection
    // --------------------------------------------------
    // only a jump that is actually taken can fetch from a bad target
    assign excp_maif = ctrl_i.jump && cond_ok && (alu_result_i[1:0] != 2'b00);

    always_comb begin
        case (ex_pkg::mem_size_e'(ctrl_i.funct3))
            ex_pkg::MEM_HALF,
            ex_pkg::MEM_HALF_U: misaligned_acc = alu_result_i[0];
            ex_pkg::MEM_WORD:   misaligned_acc = alu_result_i[1:0] != 2'b00;
            default:            misaligned_acc = 1'b0;
        endcase
    end

    assign excp_mala = ctrl_i.lq_wr && misaligned_acc;
    assign excp_masa = ctrl_i.sq_wr && misaligned_acc;

    // fetch error outranks everything else
    always_comb begin
        if (ctrl_i.ferr) begin
            cause = ex_pkg::EXCP_FETCH_ERR;
        end else if (excp_maif) begin
            cause = ex_pkg::EXCP_MISALIGNED_FETCH;
        end else if (excp_mala) begin
            cause = ex_pkg::EXCP_MISALIGNED_LOAD;
        end else if (excp_masa) begin
            cause = ex_pkg::EXCP_MISALIGNED_STORE;
        end else begin
            cause = ex_pkg::EXCP_NONE;
        end
    end

    // --------------------------------------------------
    // commit, stall and jump requests
    // --------------------------------------------------
    assign commit_raw = live && cond_ok && (cause == ex_pkg::EXCP_NONE);
    assign stall_o    = commit_raw && mem_access && lsq_full_i;
    assign stage_en_o = !stall_o;

    // held instruction writes nothing until the queue frees up
    assign commit_o      = commit_raw && stage_en_o;
    assign jump_req_o    = commit_o && ctrl_i.jump;
    assign trap_o        = live && (cause != ex_pkg::EXCP_NONE);
    assign cancel_load_o = ctrl_i.valid && ctrl_i.lq_wr && !commit_raw;

    assign excp_o.valid = trap_o;
    assign excp_o.cause = cause;
    assign excp_o.pc    = ctrl_i.pc;

    // flow state, squash until the new flow's first instruction
    always_ff @(posedge clk_i or negedge resetb_i) begin
        if (!resetb_i) begin
            flow_q <= ex_pkg::SOFID_RUN;
        end else if (stage_en_o) begin
            if (jump_req_o || trap_o) begin
                flow_q <= ex_pkg::SOFID_JUMP;
            end else if (issue_valid_i && issue_sofid_i == ex_pkg::SOFID_JUMP) begin
                flow_q <= ex_pkg::SOFID_RUN;
            end
        end
    end

    a_stall_holds: assert property (@(posedge clk_i) disable iff (!resetb_i)
        stall_o |-> (commit_raw && mem_access) ##1 $stable(ctrl_i));

    a_trap_not_commit: assert property (@(posedge clk_i) disable iff (!resetb_i)
        !(trap_o && commit_o));

    a_excp_from_run: assert property (@(posedge clk_i) disable iff (!resetb_i)
        excp_o.valid |-> (flow_q == ex_pkg::SOFID_RUN) ##1 (flow_q == ex_pkg::SOFID_JUMP));

endmodule

// File: ex_stage/ex_issue_decode.sv
`timescale 1ns/100ps

module ex_issue_decode (
    input  logic              clk_i,
    input  logic              resetb_i,
    input  logic              stage_en_i,
    input  ex_pkg::ex_issue_t issue_i,
    input  logic              issue_valid_i,
    output ex_pkg::ex_ctrl_t  ctrl_o
);

    // zone decode, one flag per destination
    logic lq_wr_d;
    logic sq_wr_d;
    logic regd_wr_d;

    logic valid_q;
    logic lq_wr_q;
    logic sq_wr_q;
    logic regd_wr_q;

    logic                            ferr_q;
    logic                            jump_q;
    logic                            cond_q;
    logic                            link_q;
    logic [ex_pkg::XLEN-1:0]         pc_q;
    logic [ex_pkg::XLEN-1:0]         pc_inc_q;
    logic [ex_pkg::XLEN-1:0]         regs2_data_q;
    logic [ex_pkg::REG_ADDR_W-1:0]   regd_addr_q;
    logic [2:0]                      funct3_q;

    always_comb begin
        lq_wr_d   = 1'b0;
        sq_wr_d   = 1'b0;
        regd_wr_d = 1'b0;
        case (issue_i.zone)
            ex_pkg::ZONE_LOADQ:   lq_wr_d   = 1'b1;
            ex_pkg::ZONE_STOREQ:  sq_wr_d   = 1'b1;
            ex_pkg::ZONE_REGFILE: regd_wr_d = 1'b1;
            default: ;
        endcase
    end

    // --------------------------------------------------
    // control flags
    // --------------------------------------------------
    always_ff @(posedge clk_i or negedge resetb_i) begin
        if (!resetb_i) begin
            valid_q   <= 1'b0;
            lq_wr_q   <= 1'b0;
            sq_wr_q   <= 1'b0;
            regd_wr_q <= 1'b0;
        end else if (stage_en_i) begin
            valid_q   <= issue_valid_i;
            lq_wr_q   <= lq_wr_d;
            sq_wr_q   <= sq_wr_d;
            regd_wr_q <= regd_wr_d;
        end
    end

    // payload, only meaningful while valid_q is set
    always_ff @(posedge clk_i) begin
        if (stage_en_i) begin
            ferr_q       <= issue_i.ferr;
            jump_q       <= issue_i.jump;
            cond_q       <= issue_i.cond;
            link_q       <= issue_i.link;
            pc_q         <= issue_i.pc;
            // ins_size counts half-words
            pc_inc_q     <= issue_i.pc + ex_pkg::XLEN'({issue_i.ins_size, 1'b0});
            regs2_data_q <= issue_i.regs2_data;
            regd_addr_q  <= issue_i.regd_addr;
            funct3_q     <= issue_i.funct3;
        end
    end

    always_comb begin
        ctrl_o.valid      = valid_q;
        ctrl_o.ferr       = ferr_q;
        ctrl_o.jump       = jump_q;
        ctrl_o.cond       = cond_q;
        ctrl_o.link       = link_q;
        ctrl_o.lq_wr      = lq_wr_q;
        ctrl_o.sq_wr      = sq_wr_q;
        ctrl_o.regd_wr    = regd_wr_q;
        ctrl_o.pc         = pc_q;
        ctrl_o.pc_inc     = pc_inc_q;
        ctrl_o.regs2_data = regs2_data_q;
        ctrl_o.regd_addr  = regd_addr_q;
        ctrl_o.funct3     = funct3_q;
    end

    a_one_write_flag: assert property (@(posedge clk_i) disable iff (!resetb_i)
        $onehot0({lq_wr_q, sq_wr_q, regd_wr_q}));

endmodule

// File: ex_stage/ex_result_mux.sv
`timescale 1ns/100ps

module ex_result_mux (
    input  ex_pkg::ex_ctrl_t        ctrl_i,
    input  logic [ex_pkg::XLEN-1:0] alu_result_i,
    input  logic                    commit_i,
    input  logic                    jump_req_i,
    input  logic                    trap_i,
    output ex_pkg::ex_wb_t          wb_o,
    output ex_pkg::ex_lsq_req_t     lsq_o,
    output logic                    jump_o,
    output logic [ex_pkg::XLEN-1:0] jump_addr_o
);

    // --------------------------------------------------
    // register write-back
    // --------------------------------------------------
    assign wb_o.wr   = commit_i && ctrl_i.regd_wr;
    assign wb_o.addr = ctrl_i.regd_addr;
    // link writes the return address
    assign wb_o.data = ctrl_i.link ? ctrl_i.pc_inc : alu_result_i;

    // --------------------------------------------------
    // load/store queue request
    // --------------------------------------------------
    assign lsq_o.lq_wr     = commit_i && ctrl_i.lq_wr;
    assign lsq_o.sq_wr     = commit_i && ctrl_i.sq_wr;
    assign lsq_o.funct3    = ctrl_i.funct3;
    assign lsq_o.regd_addr = ctrl_i.regd_addr;
    assign lsq_o.data      = ctrl_i.regs2_data;
    assign lsq_o.addr      = alu_result_i;

    // --------------------------------------------------
    // fetch redirect
    // --------------------------------------------------
    assign jump_o      = jump_req_i || trap_i;
    assign jump_addr_o = trap_i ? ex_pkg::TRAP_VECTOR : alu_result_i;

endmodule

// File: ex_stage/ex_stage.sv
`timescale 1ns/100ps

module ex_stage (
    input  logic                  clk_i,
    input  logic                  resetb_i,
    // decoder side
    input  ex_pkg::ex_issue_t     issue_i,
    input  logic                  issue_valid_i,
    output logic                  stall_o,
    // fetch side
    output logic                  jump_o,
    output logic [ex_pkg::XLEN-1:0] jump_addr_o,
    // write-back
    output ex_pkg::ex_wb_t        wb_o,
    output logic                  cancel_load_o,
    // load/store queue
    input  logic                  lsq_full_i,
    output ex_pkg::ex_lsq_req_t   lsq_o,
    // exception report
    output ex_pkg::ex_excp_t      excp_o
);

    // --------------------------------------------------
    // internal wires
    // --------------------------------------------------
    ex_pkg::ex_ctrl_t          ctrl;
    logic [ex_pkg::XLEN-1:0]   alu_result;
    logic                      cmp_true;
    logic                      stage_en;
    logic                      commit;
    logic                      jump_req;
    logic                      trap;

    ex_issue_decode u_issue_decode (
        .clk_i         (clk_i),
        .resetb_i      (resetb_i),
        .stage_en_i    (stage_en),
        .issue_i       (issue_i),
        .issue_valid_i (issue_valid_i),
        .ctrl_o        (ctrl)
    );

    ex_alu u_alu (
        .clk_i        (clk_i),
        .resetb_i     (resetb_i),
        .stage_en_i   (stage_en),
        .issue_i      (issue_i),
        .alu_result_o (alu_result),
        .cmp_true_o   (cmp_true)
    );

    ex_commit_ctrl u_commit_ctrl (
        .clk_i         (clk_i),
        .resetb_i      (resetb_i),
        .ctrl_i        (ctrl),
        .alu_result_i  (alu_result),
        .cmp_true_i    (cmp_true),
        .issue_sofid_i (issue_i.sofid),
        .issue_valid_i (issue_valid_i),
        .lsq_full_i    (lsq_full_i),
        .stage_en_o    (stage_en),
        .commit_o      (commit),
        .jump_req_o    (jump_req),
        .trap_o        (trap),
        .cancel_load_o (cancel_load_o),
        .excp_o        (excp_o),
        .stall_o       (stall_o)
    );

    ex_result_mux u_result_mux (
        .ctrl_i       (ctrl),
        .alu_result_i (alu_result),
        .commit_i     (commit),
        .jump_req_i   (jump_req),
        .trap_i       (trap),
        .wb_o         (wb_o),
        .lsq_o        (lsq_o),
        .jump_o       (jump_o),
        .jump_addr_o  (jump_addr_o)
    );

endmodule

// File: rv_ex_stage.f
+incdir+verification
common/ex_pkg.sv
ex_stage/ex_issue_decode.sv
ex_stage/ex_alu.sv
ex_stage/ex_commit_ctrl.sv
ex_stage/ex_result_mux.sv
ex_stage/ex_stage.sv
verification/ex_stage_tb.sv

// File: verification/ex_stage_tb_model.svh
// flow state of the model, mirrors the squash window after a jump
ex_pkg::sofid_e model_flow;

typedef struct packed {
    logic                mem_commit;
    logic                jump;
    logic [31:0]         jump_addr;
    logic                cancel;
    ex_pkg::ex_wb_t      wb;
    ex_pkg::ex_lsq_req_t lsq;
    ex_pkg::ex_excp_t    excp;
} expect_t;

// signed less-than from the sign bits and an unsigned compare
function automatic logic lt_signed(input logic [31:0] a, input logic [31:0] b);
    return (a[31] != b[31]) ? a[31] : (a < b);
endfunction

function automatic logic [31:0] alu_ref(input ex_pkg::alu_op_e op, input logic [31:0] a,
                                        input logic [31:0] b);
    logic [4:0]  sh;
    logic [31:0] r;
    sh = b[4:0];
    case (op)
        ex_pkg::ALU_ADD:  r = a + b;
        ex_pkg::ALU_SUB:  r = a - b;
        ex_pkg::ALU_SLL:  r = a << sh;
        ex_pkg::ALU_SLT:  r = {31'b0, lt_signed(a, b)};
        ex_pkg::ALU_SLTU: r = {31'b0, a < b};
        ex_pkg::ALU_XOR:  r = a ^ b;
        ex_pkg::ALU_SRL:  r = a >> sh;
        // fill the vacated top bits with the sign
        ex_pkg::ALU_SRA:  r = (a >> sh) | (~(32'hffff_ffff >> sh) & {32{a[31]}});
        ex_pkg::ALU_OR:   r = a | b;
        ex_pkg::ALU_AND:  r = a & b;
        default:          r = '0;
    endcase
    return r;
endfunction

function automatic logic cmp_ref(input ex_pkg::cmp_op_e op, input logic [31:0] a,
                                 input logic [31:0] b);
    case (op)
        ex_pkg::CMP_EQ:  return a == b;
        ex_pkg::CMP_NE:  return a != b;
        ex_pkg::CMP_LT:  return lt_signed(a, b);
        ex_pkg::CMP_GE:  return !lt_signed(a, b);
        ex_pkg::CMP_LTU: return a < b;
        ex_pkg::CMP_GEU: return a >= b;
        default:         return 1'b0;
    endcase
endfunction

// expected outputs for the cycle after ins is accepted
function automatic expect_t predict(input ex_pkg::ex_issue_t ins, input logic vld,
                                    input logic prev_jump);
    expect_t             e;
    logic [31:0]         res;
    logic                cond_ok;
    logic                mis;
    logic                live;
    logic                commit;
    logic                is_ld;
    logic                is_st;
    ex_pkg::excp_cause_e cause;
    // an older jump wins over a new flow tag on the same edge
    if (prev_jump) begin
        model_flow = ex_pkg::SOFID_JUMP;
    end else if (vld && ins.sofid == ex_pkg::SOFID_JUMP) begin
        model_flow = ex_pkg::SOFID_RUN;
    end
    e       = '0;
    res     = alu_ref(ins.alu_op, ins.operand_left, ins.operand_right);
    cond_ok = !ins.cond || cmp_ref(ins.cmp_op, ins.regs1_data, ins.cmp_right);
    is_ld   = ins.zone == ex_pkg::ZONE_LOADQ;
    is_st   = ins.zone == ex_pkg::ZONE_STOREQ;
    case (ins.funct3)
        3'b001, 3'b101: mis = res[0];
        3'b010:         mis = res[1:0] != 2'b00;
        default:        mis = 1'b0;
    endcase
    if (ins.ferr) cause = ex_pkg::EXCP_FETCH_ERR;
    else if (ins.jump && cond_ok && res[1:0] != 2'b00) cause = ex_pkg::EXCP_MISALIGNED_FETCH;
    else if (is_ld && mis) cause = ex_pkg::EXCP_MISALIGNED_LOAD;
    else if (is_st && mis) cause = ex_pkg::EXCP_MISALIGNED_STORE;
    else cause = ex_pkg::EXCP_NONE;
    live            = vld && model_flow == ex_pkg::SOFID_RUN;
    commit          = live && cond_ok && cause == ex_pkg::EXCP_NONE;
    e.mem_commit    = commit && (is_ld || is_st);
    e.wb.wr         = commit && ins.zone == ex_pkg::ZONE_REGFILE;
    e.wb.addr       = ins.regd_addr;
    e.wb.data       = ins.link ? ins.pc + 32'(ins.ins_size) * 32'd2 : res;
    e.lsq.lq_wr     = commit && is_ld;
    e.lsq.sq_wr     = commit && is_st;
    e.lsq.funct3    = ins.funct3;
    e.lsq.regd_addr = ins.regd_addr;
    e.lsq.data      = ins.regs2_data;
    e.lsq.addr      = res;
    e.excp.valid    = live && cause != ex_pkg::EXCP_NONE;
    e.excp.cause    = cause;
    e.excp.pc       = ins.pc;
    e.jump          = (commit && ins.jump) || e.excp.valid;
    e.jump_addr     = e.excp.valid ? ex_pkg::TRAP_VECTOR : res;
    e.cancel        = vld && is_ld && !commit;
    return e;
endfunction

// File: verification/ex_stage_tb.sv
`timescale 1ns/100ps

module ex_stage_tb;

    localparam int WAIT_LIMIT = 20;

    logic                    clk_i;
    logic                    resetb_i;
    ex_pkg::ex_issue_t       issue_i;
    logic                    issue_valid_i;
    logic                    lsq_full_i;
    logic                    stall_o;
    logic                    jump_o;
    logic [ex_pkg::XLEN-1:0] jump_addr_o;
    ex_pkg::ex_wb_t          wb_o;
    logic                    cancel_load_o;
    ex_pkg::ex_lsq_req_t     lsq_o;
    ex_pkg::ex_excp_t        excp_o;

    int      errors;
    int      checks;
    int      test_errors;
    int      mem_writes;
    int      seed_val;
    logic    stall_exp;

    `include "ex_stage_tb_model.svh"

    expect_t cur;

    ex_stage dut0 (
        .clk_i         (clk_i),
        .resetb_i      (resetb_i),
        .issue_i       (issue_i),
        .issue_valid_i (issue_valid_i),
        .stall_o       (stall_o),
        .jump_o        (jump_o),
        .jump_addr_o   (jump_addr_o),
        .wb_o          (wb_o),
        .cancel_load_o (cancel_load_o),
        .lsq_full_i    (lsq_full_i),
        .lsq_o         (lsq_o),
        .excp_o        (excp_o)
    );

    always #20 clk_i = ~clk_i;

    // --------------------------------------------------
    // checking
    // --------------------------------------------------
    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("Error: %s = %h, expected %h at %0t", name, got, exp, $time);
            errors++;
        end
    endtask

    // outputs are settled mid-cycle, the next instruction is taken at the rising edge
    always @(negedge clk_i) begin
        if (!resetb_i) begin
            model_flow = ex_pkg::SOFID_RUN;
            cur        = '0;
        end else begin
            stall_exp = cur.mem_commit && lsq_full_i;
            check_val("stall_o", stall_o, stall_exp);
            check_val("wb_o.wr", wb_o.wr, cur.wb.wr);
            if (cur.wb.wr) begin
                check_val("wb_o.addr", wb_o.addr, cur.wb.addr);
                check_val("wb_o.data", wb_o.data, cur.wb.data);
            end
            check_val("lsq_o.lq_wr", lsq_o.lq_wr, cur.lsq.lq_wr && !stall_exp);
            check_val("lsq_o.sq_wr", lsq_o.sq_wr, cur.lsq.sq_wr && !stall_exp);
            if ((cur.lsq.lq_wr || cur.lsq.sq_wr) && !stall_exp) begin
                check_val("lsq_o.funct3", lsq_o.funct3, cur.lsq.funct3);
                check_val("lsq_o.regd_addr", lsq_o.regd_addr, cur.lsq.regd_addr);
                check_val("lsq_o.data", lsq_o.data, cur.lsq.data);
                check_val("lsq_o.addr", lsq_o.addr, cur.lsq.addr);
            end
            check_val("jump_o", jump_o, cur.jump);
            if (cur.jump) begin
                check_val("jump_addr_o", jump_addr_o, cur.jump_addr);
            end
            check_val("cancel_load_o", cancel_load_o, cur.cancel);
            check_val("excp_o.valid", excp_o.valid, cur.excp.valid);
            if (cur.excp.valid) begin
                check_val("excp_o.cause", 32'(excp_o.cause), 32'(cur.excp.cause));
                check_val("excp_o.pc", excp_o.pc, cur.excp.pc);
            end
            if (!stall_exp) begin
                cur = predict(issue_i, issue_valid_i, cur.jump);
            end
            if (lsq_o.lq_wr || lsq_o.sq_wr) begin
                mem_writes++;
            end
        end
    end

    // --------------------------------------------------
    // stimulus helpers
    // --------------------------------------------------
    function automatic ex_pkg::ex_issue_t make_ins(input ex_pkg::sofid_e tag,
                                                   input ex_pkg::zone_e zone);
        ex_pkg::ex_issue_t ins;
        ins               = '0;
        ins.sofid         = tag;
        ins.zone          = zone;
        ins.ins_size      = 2'($urandom % 4);
        ins.pc            = $urandom & 32'h0000_fffc;
        ins.alu_op        = ex_pkg::alu_op_e'($urandom % 10);
        ins.operand_left  = $urandom;
        ins.operand_right = $urandom;
        ins.cmp_op        = ex_pkg::CMP_EQ;
        ins.regs1_data    = $urandom;
        ins.regs2_data    = $urandom;
        ins.regd_addr     = 5'($urandom % 32);
        return ins;
    endfunction

    function automatic ex_pkg::ex_issue_t mem_ins(input ex_pkg::zone_e zone,
                                                  input logic [2:0] size,
                                                  input logic [1:0] offset);
        ex_pkg::ex_issue_t ins;
        ins               = make_ins(ex_pkg::SOFID_RUN, zone);
        ins.alu_op        = ex_pkg::ALU_ADD;
        ins.operand_left  = $urandom & 32'hffff_fff0;
        ins.operand_right = {30'($urandom % 64), offset};
        ins.funct3        = size;
        return ins;
    endfunction

    // target is pc plus an offset whose low bits are given
    function automatic ex_pkg::ex_issue_t jump_ins(input logic cond, input logic link,
                                                   input ex_pkg::cmp_op_e cmp,
                                                   input logic [31:0] a, input logic [31:0] b,
                                                   input logic [1:0] low);
        ex_pkg::ex_issue_t ins;
        ins = make_ins(ex_pkg::SOFID_RUN, link ? ex_pkg::ZONE_REGFILE : ex_pkg::ZONE_NONE);
        ins.jump          = 1'b1;
        ins.cond          = cond;
        ins.link          = link;
        ins.alu_op        = ex_pkg::ALU_ADD;
        ins.operand_left  = ins.pc;
        ins.operand_right = ($urandom & 32'h0000_0ffc) | 32'(low);
        ins.cmp_op        = cmp;
        ins.regs1_data    = a;
        ins.cmp_right     = b;
        return ins;
    endfunction

    function automatic ex_pkg::cmp_op_e rand_cmp();
        case ($urandom % 6)
            0:       return ex_pkg::CMP_EQ;
            1:       return ex_pkg::CMP_NE;
            2:       return ex_pkg::CMP_LT;
            3:       return ex_pkg::CMP_GE;
            4:       return ex_pkg::CMP_LTU;
            default: return ex_pkg::CMP_GEU;
        endcase
    endfunction

    function automatic logic [2:0] mem_size(input int k);
        case (k)
            0:       return ex_pkg::MEM_BYTE;
            1:       return ex_pkg::MEM_HALF;
            2:       return ex_pkg::MEM_WORD;
            3:       return ex_pkg::MEM_BYTE_U;
            default: return ex_pkg::MEM_HALF_U;
        endcase
    endfunction

    task automatic stop_on_timeout(input string what);
        $display("timeout: %s did not happen within %0d cycles", what, WAIT_LIMIT);
        $display("test failed");
        $finish;
    endtask

    // called 1 ns after a rising edge, returns 1 ns after the accepting edge
    task automatic send(input ex_pkg::ex_issue_t ins, input logic vld);
        int waited;
        issue_i       = ins;
        issue_valid_i = vld;
        waited        = 0;
        @(negedge clk_i);
        while (stall_o) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                stop_on_timeout("stall release");
            end
            @(negedge clk_i);
        end
        @(posedge clk_i);
        #1;
    endtask

    // squashed slot, then the first instruction of a new flow
    task automatic resync();
        send(make_ins(ex_pkg::SOFID_RUN, ex_pkg::ZONE_NONE), 1'b0);
        send(make_ins(ex_pkg::SOFID_JUMP, ex_pkg::ZONE_NONE), 1'b1);
    endtask

    task automatic end_test(input string name);
        $display("%-14s done, errors %0d", name, errors - test_errors);
        test_errors = errors;
    endtask

    // --------------------------------------------------
    // tests
    // --------------------------------------------------
    initial begin
        ex_pkg::ex_issue_t ins;
        ex_pkg::ex_issue_t nxt;
        clk_i         = 1'b0;
        resetb_i      = 1'b0;
        issue_i       = '0;
        issue_valid_i = 1'b0;
        lsq_full_i    = 1'b0;
        errors        = 0;
        checks        = 0;
        test_errors   = 0;
        mem_writes    = 0;
        seed_val      = $urandom(32'h23c4fceb);
        repeat (5) @(posedge clk_i);
        #1;
        resetb_i = 1'b1;

        @(negedge clk_i);
        check_val("stall_o", stall_o, 0);
        check_val("jump_o", jump_o, 0);
        check_val("wb_o.wr", wb_o.wr, 0);
        check_val("lsq_o.lq_wr", lsq_o.lq_wr, 0);
        check_val("lsq_o.sq_wr", lsq_o.sq_wr, 0);
        check_val("cancel_load_o", cancel_load_o, 0);
        check_val("excp_o.valid", excp_o.valid, 0);
        @(posedge clk_i);
        #1;
        end_test("reset");

        for (int i = 0; i < 40; i++) begin
            ins      = make_ins(ex_pkg::SOFID_RUN, ex_pkg::ZONE_REGFILE);
            ins.link = ($urandom % 4) == 0;
            send(ins, 1'b1);
        end
        end_test("alu");

        // taken ones squash the load and the next RUN instruction
        for (int i = 0; i < 12; i++) begin
            send(jump_ins(i % 3 != 0, i % 3 == 0, rand_cmp(), $urandom % 4, $urandom % 4,
                          2'b00), 1'b1);
            send(mem_ins(ex_pkg::ZONE_LOADQ, ex_pkg::MEM_WORD, 2'b00), 1'b1);
            send(make_ins(ex_pkg::SOFID_RUN, ex_pkg::ZONE_REGFILE), 1'b1);
            send(make_ins(ex_pkg::SOFID_JUMP, ex_pkg::ZONE_REGFILE), 1'b1);
            send(make_ins(ex_pkg::SOFID_RUN, ex_pkg::ZONE_REGFILE), 1'b1);
        end
        end_test("branch");

        for (int sz = 0; sz < 5; sz++) begin
            for (int off = 0; off < 4; off++) begin
                send(mem_ins(ex_pkg::ZONE_LOADQ, mem_size(sz), 2'(off)), 1'b1);
                resync();
                send(mem_ins(ex_pkg::ZONE_STOREQ, mem_size(sz), 2'(off)), 1'b1);
                resync();
            end
        end
        end_test("load_store");

        for (int off = 0; off < 4; off++) begin
            send(jump_ins(1'b0, 1'b1, ex_pkg::CMP_EQ, 0, 0, 2'(off)), 1'b1);
            resync();
            ins      = mem_ins(ex_pkg::ZONE_LOADQ, ex_pkg::MEM_WORD, 2'(off));
            ins.ferr = 1'b1;
            send(ins, 1'b1);
            resync();
        end
        // not taken, so the bad target is never fetched
        send(jump_ins(1'b1, 1'b0, ex_pkg::CMP_NE, 5, 5, 2'b10), 1'b1);
        resync();
        end_test("exception");

        for (int st = 0; st < 2; st++) begin
            lsq_full_i = 1'b1;
            send(make_ins(ex_pkg::SOFID_RUN, ex_pkg::ZONE_REGFILE), 1'b1);
            mem_writes = 0;
            send(mem_ins(st ? ex_pkg::ZONE_STOREQ : ex_pkg::ZONE_LOADQ, ex_pkg::MEM_WORD,
                         2'b00), 1'b1);
            // decoder holds the next instruction while stalled
            nxt     = make_ins(ex_pkg::SOFID_RUN, ex_pkg::ZONE_REGFILE);
            issue_i = nxt;
            repeat (4) begin
                @(posedge clk_i);
                #1;
            end
            lsq_full_i = 1'b0;
            send(nxt, 1'b1);
            send(make_ins(ex_pkg::SOFID_RUN, ex_pkg::ZONE_NONE), 1'b0);
            check_val("queue write count", mem_writes, 1);
        end
        end_test("backpressure");

        send(make_ins(ex_pkg::SOFID_RUN, ex_pkg::ZONE_NONE), 1'b0);
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule
